/* rtl/apb_bridge_pkg.sv */
`default_nettype none

package apb_bridge_pkg;

    // APB bus widths
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int PROT_W = 3;

    // Command packet, top bit down: write, prot, strb, addr, wdata
    localparam int CMD_W         = 1 + PROT_W + STRB_W + ADDR_W + DATA_W;
    localparam int CMD_WDATA_LSB = 0;
    localparam int CMD_ADDR_LSB  = CMD_WDATA_LSB + DATA_W;
    localparam int CMD_STRB_LSB  = CMD_ADDR_LSB + ADDR_W;
    localparam int CMD_PROT_LSB  = CMD_STRB_LSB + STRB_W;
    localparam int CMD_WRITE_BIT = CMD_PROT_LSB + PROT_W;

    // Response packet is {pslverr, prdata}
    localparam int RSP_W       = DATA_W + 1;
    localparam int RSP_ERR_BIT = DATA_W;

    localparam int CMD_DEPTH = 4;
    localparam int RSP_DEPTH = 4;

    // Register bank
    localparam int REG_COUNT   = 16;
    localparam int REG_IDX_LSB = 2;

    // Read-only word at register 0
    localparam logic [DATA_W-1:0] ID_VALUE = 32'h4150_4231;

endpackage

`default_nettype wire

/* rtl/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              aclk,
    input  wire              aresetn,

    input  wire              i_wr_valid,
    output logic             o_wr_ready,
    input  wire [WIDTH-1:0]  i_wr_data,

    output logic             o_rd_valid,
    input  wire              i_rd_ready,
    output logic [WIDTH-1:0] o_rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic             w_push;
    logic             w_pop;

    assign o_wr_ready = (r_count != CNT_W'(DEPTH));
    assign o_rd_valid = (r_count != '0);
    assign o_rd_data  = r_mem[r_rd_ptr];

    assign w_push = i_wr_valid && o_wr_ready;
    assign w_pop  = o_rd_valid && i_rd_ready;

    // Storage only, no reset needed on the payload
    always_ff @(posedge aclk) begin
        if (w_push) begin
            r_mem[r_wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (w_push) begin
                if (r_wr_ptr == PTR_W'(DEPTH - 1)) begin
                    r_wr_ptr <= '0;
                end else begin
                    r_wr_ptr <= r_wr_ptr + 1'b1;
                end
            end
            if (w_pop) begin
                if (r_rd_ptr == PTR_W'(DEPTH - 1)) begin
                    r_rd_ptr <= '0;
                end else begin
                    r_rd_ptr <= r_rd_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_count <= '0;
        end else begin
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_master.sv */
`default_nettype none

module apb_master (
    input  wire                                 aclk,
    input  wire                                 aresetn,

    // Command port
    input  wire                                 i_cmd_valid,
    output logic                                o_cmd_ready,
    input  wire [apb_bridge_pkg::CMD_W-1:0]     i_cmd_data,

    // Read response port
    output logic                                o_rsp_valid,
    input  wire                                 i_rsp_ready,
    output logic [apb_bridge_pkg::RSP_W-1:0]    o_rsp_data,

    // APB master side
    output logic                                o_psel,
    output logic                                o_penable,
    output logic                                o_pwrite,
    output logic [apb_bridge_pkg::ADDR_W-1:0]   o_paddr,
    output logic [apb_bridge_pkg::DATA_W-1:0]   o_pwdata,
    output logic [apb_bridge_pkg::STRB_W-1:0]   o_pstrb,
    output logic [apb_bridge_pkg::PROT_W-1:0]   o_pprot,
    input  wire [apb_bridge_pkg::DATA_W-1:0]    i_prdata,
    input  wire                                 i_pready,
    input  wire                                 i_pslverr
);

    logic                                         w_cmd_rd_valid;
    logic                                         w_cmd_rd_ready;
    logic [apb_bridge_pkg::CMD_W-1:0]             w_cmd_rd_data;
    logic                                         w_rsp_wr_valid;
    logic                                         w_rsp_wr_ready;
    logic [apb_bridge_pkg::RSP_W-1:0]             w_rsp_wr_data;

    logic [apb_bridge_pkg::CMD_W-1:0]             r_cmd;
    logic                                         r_psel;
    logic                                         r_penable;
    logic [$clog2(apb_bridge_pkg::RSP_DEPTH+1)-1:0] r_rsp_used;

    logic                                         w_head_write;
    logic                                         w_read_ok;
    logic                                         w_done;
    logic                                         w_pop;
    logic                                         w_take_read;
    logic                                         w_rsp_out;

    sync_fifo #(
        .WIDTH (apb_bridge_pkg::CMD_W),
        .DEPTH (apb_bridge_pkg::CMD_DEPTH)
    ) u_cmd_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (i_cmd_valid),
        .o_wr_ready (o_cmd_ready),
        .i_wr_data  (i_cmd_data),
        .o_rd_valid (w_cmd_rd_valid),
        .i_rd_ready (w_cmd_rd_ready),
        .o_rd_data  (w_cmd_rd_data)
    );

    sync_fifo #(
        .WIDTH (apb_bridge_pkg::RSP_W),
        .DEPTH (apb_bridge_pkg::RSP_DEPTH)
    ) u_rsp_fifo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr_valid (w_rsp_wr_valid),
        .o_wr_ready (w_rsp_wr_ready),
        .i_wr_data  (w_rsp_wr_data),
        .o_rd_valid (o_rsp_valid),
        .i_rd_ready (i_rsp_ready),
        .o_rd_data  (o_rsp_data)
    );

    // State is carried by psel/penable: 00 IDLE, 10 SETUP, 11 ACCESS
    assign w_done       = r_psel && r_penable && i_pready;
    assign w_head_write = w_cmd_rd_data[apb_bridge_pkg::CMD_WRITE_BIT];

    // A read needs a response slot that no earlier read has claimed
    assign w_read_ok    = w_rsp_wr_ready &&
                          (r_rsp_used != apb_bridge_pkg::RSP_DEPTH);

    assign w_cmd_rd_ready = (!r_psel || w_done) && (w_head_write || w_read_ok);
    assign w_pop          = w_cmd_rd_valid && w_cmd_rd_ready;
    assign w_take_read    = w_pop && !w_head_write;
    assign w_rsp_out      = o_rsp_valid && i_rsp_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_psel    <= 1'b0;
            r_penable <= 1'b0;
        end else if (w_pop) begin
            r_psel    <= 1'b1;
            r_penable <= 1'b0;
        end else if (r_psel && !r_penable) begin
            r_penable <= 1'b1;
        end else if (w_done) begin
            r_psel    <= 1'b0;
            r_penable <= 1'b0;
        end
    end

    // Held from setup until the end of access
    always_ff @(posedge aclk) begin
        if (w_pop) begin
            r_cmd <= w_cmd_rd_data;
        end
    end

    // Slots claimed by reads in flight or waiting in the response FIFO
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_rsp_used <= '0;
        end else begin
            case ({w_take_read, w_rsp_out})
                2'b10:   r_rsp_used <= r_rsp_used + 1'b1;
                2'b01:   r_rsp_used <= r_rsp_used - 1'b1;
                default: r_rsp_used <= r_rsp_used;
            endcase
        end
    end

    // Only reads report back; write errors are dropped
    assign w_rsp_wr_valid = w_done && !r_cmd[apb_bridge_pkg::CMD_WRITE_BIT];
    assign w_rsp_wr_data  = {i_pslverr, i_prdata};

    assign o_psel    = r_psel;
    assign o_penable = r_penable;
    assign o_pwrite  = r_cmd[apb_bridge_pkg::CMD_WRITE_BIT];
    assign o_paddr   = r_cmd[apb_bridge_pkg::CMD_ADDR_LSB +: apb_bridge_pkg::ADDR_W];
    assign o_pwdata  = r_cmd[apb_bridge_pkg::CMD_WDATA_LSB +: apb_bridge_pkg::DATA_W];
    assign o_pstrb   = r_cmd[apb_bridge_pkg::CMD_STRB_LSB +: apb_bridge_pkg::STRB_W];
    assign o_pprot   = r_cmd[apb_bridge_pkg::CMD_PROT_LSB +: apb_bridge_pkg::PROT_W];

endmodule

`default_nettype wire

/* rtl/apb_reg_slave.sv */
`default_nettype none

module apb_reg_slave (
    input  wire                                 aclk,
    input  wire                                 aresetn,

    input  wire                                 i_psel,
    input  wire                                 i_penable,
    input  wire                                 i_pwrite,
    input  wire [apb_bridge_pkg::ADDR_W-1:0]    i_paddr,
    input  wire [apb_bridge_pkg::DATA_W-1:0]    i_pwdata,
    input  wire [apb_bridge_pkg::STRB_W-1:0]    i_pstrb,
    // Protection is accepted but not decoded
    input  wire [apb_bridge_pkg::PROT_W-1:0]    i_pprot,

    output logic [apb_bridge_pkg::DATA_W-1:0]   o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr
);

    logic [apb_bridge_pkg::DATA_W-1:0]            r_regs [apb_bridge_pkg::REG_COUNT];
    logic [1:0]                                   r_wait;
    logic [$clog2(apb_bridge_pkg::REG_COUNT)-1:0] w_idx;
    logic                                         w_setup;
    logic                                         w_access;
    logic                                         w_done;
    logic                                         w_oor;
    logic                                         w_wr_en;

    assign w_setup  = i_psel && !i_penable;
    assign w_access = i_psel && i_penable;
    assign w_done   = w_access && (r_wait == 2'd0);

    // Index from bits 5:2, byte offset bits ignored
    assign w_idx = i_paddr[apb_bridge_pkg::REG_IDX_LSB +: $clog2(apb_bridge_pkg::REG_COUNT)];

    // Anything above the index field is outside the bank
    assign w_oor = (i_paddr >> (apb_bridge_pkg::REG_IDX_LSB +
                                $clog2(apb_bridge_pkg::REG_COUNT))) != '0;

    // Register 0 is the ID word and never takes a write
    assign w_wr_en = w_done && i_pwrite && !w_oor && (w_idx != '0);

    // Wait states taken from address bits 3:2
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wait <= 2'd0;
        end else if (w_setup) begin
            r_wait <= i_paddr[apb_bridge_pkg::REG_IDX_LSB +: 2];
        end else if (w_access && (r_wait != 2'd0)) begin
            r_wait <= r_wait - 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < apb_bridge_pkg::REG_COUNT; i++) begin
                if (i == 0) begin
                    r_regs[i] <= apb_bridge_pkg::ID_VALUE;
                end else begin
                    r_regs[i] <= '0;
                end
            end
        end else if (w_wr_en) begin
            for (int b = 0; b < apb_bridge_pkg::STRB_W; b++) begin
                if (i_pstrb[b]) begin
                    r_regs[w_idx][8*b +: 8] <= i_pwdata[8*b +: 8];
                end
            end
        end
    end

    // Read data follows the address; the master samples it at pready
    assign o_prdata  = w_oor ? '0 : r_regs[w_idx];
    assign o_pready  = w_done;
    assign o_pslverr = w_done && w_oor;

endmodule

`default_nettype wire

/* rtl/apb_bridge_top.sv */
`default_nettype none

module apb_bridge_top (
    input  wire                                 aclk,
    input  wire                                 aresetn,

    input  wire                                 i_cmd_valid,
    output logic                                o_cmd_ready,
    input  wire [apb_bridge_pkg::CMD_W-1:0]     i_cmd_data,

    output logic                                o_rsp_valid,
    input  wire                                 i_rsp_ready,
    output logic [apb_bridge_pkg::RSP_W-1:0]    o_rsp_data,

    // Bus monitor taps
    output logic                                o_apb_psel,
    output logic                                o_apb_penable,
    output logic                                o_apb_pwrite,
    output logic [apb_bridge_pkg::ADDR_W-1:0]   o_apb_paddr
);

    logic [apb_bridge_pkg::DATA_W-1:0] w_pwdata;
    logic [apb_bridge_pkg::STRB_W-1:0] w_pstrb;
    logic [apb_bridge_pkg::PROT_W-1:0] w_pprot;
    logic [apb_bridge_pkg::DATA_W-1:0] w_prdata;
    logic                              w_pready;
    logic                              w_pslverr;

    apb_master u_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd_data  (i_cmd_data),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_data  (o_rsp_data),
        .o_psel      (o_apb_psel),
        .o_penable   (o_apb_penable),
        .o_pwrite    (o_apb_pwrite),
        .o_paddr     (o_apb_paddr),
        .o_pwdata    (w_pwdata),
        .o_pstrb     (w_pstrb),
        .o_pprot     (w_pprot),
        .i_prdata    (w_prdata),
        .i_pready    (w_pready),
        .i_pslverr   (w_pslverr)
    );

    apb_reg_slave u_slave (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_psel    (o_apb_psel),
        .i_penable (o_apb_penable),
        .i_pwrite  (o_apb_pwrite),
        .i_paddr   (o_apb_paddr),
        .i_pwdata  (w_pwdata),
        .i_pstrb   (w_pstrb),
        .i_pprot   (w_pprot),
        .o_prdata  (w_prdata),
        .o_pready  (w_pready),
        .o_pslverr (w_pslverr)
    );

endmodule

`default_nettype wire

/* tb/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h8926ff5b;

int error_count = 0;
int check_count = 0;

function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], next_rand_bit()};
    end
    return v;
endfunction

task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
endtask

`endif

/* tb/tb_apb_bridge.sv */
`default_nettype none

module tb_apb_bridge;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int RAND_CMDS      = 300;

    logic                                aclk;
    logic                                aresetn;
    logic                                i_cmd_valid;
    logic                                o_cmd_ready;
    logic [apb_bridge_pkg::CMD_W-1:0]    i_cmd_data;
    logic                                o_rsp_valid;
    logic                                i_rsp_ready;
    logic [apb_bridge_pkg::RSP_W-1:0]    o_rsp_data;
    logic                                o_apb_psel;
    logic                                o_apb_penable;
    logic                                o_apb_pwrite;
    logic [apb_bridge_pkg::ADDR_W-1:0]   o_apb_paddr;

    logic [apb_bridge_pkg::DATA_W-1:0]   model_regs [apb_bridge_pkg::REG_COUNT];
    logic [apb_bridge_pkg::RSP_W-1:0]    expected_q [$];
    // Accepted commands as {write, addr}, in bus order
    logic [apb_bridge_pkg::ADDR_W:0]     xfer_q [$];

    // 0 always ready, 1 random, 2 held low
    int rsp_mode    = 2;

    logic                                prev_resetn  = 1'b0;
    logic                                prev_psel    = 1'b0;
    logic                                prev_penable = 1'b0;
    logic                                prev_pwrite  = 1'b0;
    logic [apb_bridge_pkg::ADDR_W-1:0]   prev_paddr   = '0;

    `include "tb_util.svh"

    apb_bridge_top i_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_cmd_valid   (i_cmd_valid),
        .o_cmd_ready   (o_cmd_ready),
        .i_cmd_data    (i_cmd_data),
        .o_rsp_valid   (o_rsp_valid),
        .i_rsp_ready   (i_rsp_ready),
        .o_rsp_data    (o_rsp_data),
        .o_apb_psel    (o_apb_psel),
        .o_apb_penable (o_apb_penable),
        .o_apb_pwrite  (o_apb_pwrite),
        .o_apb_paddr   (o_apb_paddr)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        i_rsp_ready = 1'b0;
        forever begin
            @(posedge aclk);
            #2;
            case (rsp_mode)
                0:       i_rsp_ready = 1'b1;
                1:       i_rsp_ready = (rand_bits(2) != 0);
                default: i_rsp_ready = 1'b0;
            endcase
        end
    end

    // Scoreboard, sampled mid-cycle where the handshake is settled
    always @(negedge aclk) begin
        if (aresetn && o_rsp_valid && i_rsp_ready) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Response at %0t ns arrived with no read outstanding", $time);
            end else begin
                check_eq(o_rsp_data, expected_q.pop_front(), "read response");
            end
        end
    end

    // APB protocol monitor
    always @(negedge aclk) begin
        if (!aresetn || !prev_resetn) begin
            check_eq({o_apb_psel, o_apb_penable}, 2'b00, "select and enable low around reset");
        end else begin
            if (o_apb_psel && !o_apb_penable) begin
                if (xfer_q.size() == 0) begin
                    error_count++;
                    $display("Setup phase at %0t ns with no command outstanding", $time);
                end else begin
                    check_eq({o_apb_pwrite, o_apb_paddr}, xfer_q.pop_front(),
                             "transfer direction and address");
                end
            end
            if (prev_psel && !prev_penable) begin
                check_eq({o_apb_psel, o_apb_penable}, 2'b11, "access after one setup cycle");
            end
            if (o_apb_penable) begin
                check_eq(prev_psel, 1'b1, "enable only after select");
                check_eq({o_apb_paddr, o_apb_pwrite}, {prev_paddr, prev_pwrite},
                         "address and write stable during transfer");
            end
        end
        prev_resetn  = aresetn;
        prev_psel    = o_apb_psel;
        prev_penable = o_apb_penable;
        prev_pwrite  = o_apb_pwrite;
        prev_paddr   = o_apb_paddr;
    end

    task automatic abort_run(input string what);
        $display("%s at %0t ns", what, $time);
        $display("Test failures found");
        $finish;
    endtask

    function automatic logic [apb_bridge_pkg::CMD_W-1:0] pack_cmd(
        input logic wr, input logic [2:0] prot, input logic [3:0] strb,
        input logic [11:0] addr, input logic [31:0] wdata);
        logic [apb_bridge_pkg::CMD_W-1:0] pkt;
        pkt = '0;
        pkt[apb_bridge_pkg::CMD_WRITE_BIT] = wr;
        pkt[apb_bridge_pkg::CMD_PROT_LSB +: apb_bridge_pkg::PROT_W]  = prot;
        pkt[apb_bridge_pkg::CMD_STRB_LSB +: apb_bridge_pkg::STRB_W]  = strb;
        pkt[apb_bridge_pkg::CMD_ADDR_LSB +: apb_bridge_pkg::ADDR_W]  = addr;
        pkt[apb_bridge_pkg::CMD_WDATA_LSB +: apb_bridge_pkg::DATA_W] = wdata;
        return pkt;
    endfunction

    task automatic send_cmd(input logic [apb_bridge_pkg::CMD_W-1:0] pkt);
        int waited;
        waited = 0;
        i_cmd_valid = 1'b1;
        i_cmd_data  = pkt;
        @(negedge aclk);
        while (!o_cmd_ready) begin
            if (waited >= TIMEOUT_CYCLES) begin
                abort_run("Command port never became ready");
            end
            waited++;
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
        i_cmd_valid = 1'b0;
    endtask

    // Model is updated at acceptance since the bridge keeps order
    task automatic issue(input logic wr, input logic [11:0] addr,
                         input logic [31:0] wdata, input logic [3:0] strb);
        logic [3:0] idx;
        logic       in_bank;
        idx     = addr[5:2];
        in_bank = (addr[11:6] == '0);
        send_cmd(pack_cmd(wr, 3'(rand_bits(3)), strb, addr, wdata));
        xfer_q.push_back({wr, addr});
        if (wr) begin
            // Writes outside the bank or to register 0 are ignored
            if (in_bank && idx != 0) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        model_regs[idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
        end else if (!in_bank) begin
            expected_q.push_back({1'b1, 32'h0});
        end else if (idx == 0) begin
            expected_q.push_back({1'b0, apb_bridge_pkg::ID_VALUE});
        end else begin
            expected_q.push_back({1'b0, model_regs[idx]});
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 || xfer_q.size() != 0) begin
            if (waited >= TIMEOUT_CYCLES) begin
                abort_run("Outstanding reads or transfers never completed");
            end
            waited++;
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
    endtask

    task automatic wait_cmd_stall();
        int waited;
        waited = 0;
        @(negedge aclk);
        while (o_cmd_ready) begin
            if (waited >= TIMEOUT_CYCLES) begin
                abort_run("Command port never stalled under response back-pressure");
            end
            waited++;
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
    endtask

    initial begin
        logic [11:0] addr;
        aresetn     = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd_data  = '0;
        for (int r = 0; r < apb_bridge_pkg::REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge aclk);
        #2;
        aresetn  = 1'b1;
        rsp_mode = 0;

        // Full and strobed writes, each read back
        for (int r = 1; r < apb_bridge_pkg::REG_COUNT; r++) begin
            addr = 12'(r << 2) | 12'(rand_bits(2));
            issue(1'b1, addr, rand_bits(32), 4'hf);
            issue(1'b0, addr, '0, '0);
            issue(1'b1, addr, rand_bits(32), 4'(rand_bits(4)));
            issue(1'b0, addr, '0, '0);
        end
        wait_drain();

        // ID register
        issue(1'b0, 12'h000, '0, '0);
        issue(1'b1, 12'h000, rand_bits(32), 4'hf);
        issue(1'b0, 12'h000, '0, '0);
        wait_drain();

        // Out-of-bank addresses, then a sweep of the whole bank
        repeat (20) begin
            addr = 12'(rand_bits(12));
            if (addr[11:6] == '0) begin
                addr[11] = 1'b1;
            end
            issue(next_rand_bit(), addr, rand_bits(32), 4'(rand_bits(4)));
            issue(1'b0, addr, '0, '0);
        end
        for (int r = 0; r < apb_bridge_pkg::REG_COUNT; r++) begin
            issue(1'b0, 12'(r << 2), '0, '0);
        end
        wait_drain();

        // Random mixed traffic with gaps and response stalls
        rsp_mode = 1;
        for (int n = 0; n < RAND_CMDS; n++) begin
            addr = 12'(rand_bits(6));
            if (rand_bits(3) == 0) begin
                addr[11:6] = 6'(rand_bits(6)) | 6'd1;
            end
            issue(next_rand_bit(), addr, rand_bits(32), 4'(rand_bits(4)));
            repeat (rand_bits(2)) begin
                @(posedge aclk);
                #2;
            end
        end
        wait_drain();

        // Fill both FIFOs while the response port is held off
        rsp_mode = 2;
        @(posedge aclk);
        #2;
        for (int n = 0; n < apb_bridge_pkg::RSP_DEPTH + apb_bridge_pkg::CMD_DEPTH; n++) begin
            issue(1'b0, 12'(rand_bits(6)), '0, '0);
        end
        wait_cmd_stall();
        check_eq(o_rsp_valid, 1'b1, "responses waiting while ready held low");
        rsp_mode = 0;
        wait_drain();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* apb_bridge.f */
+incdir+tb
rtl/apb_bridge_pkg.sv
rtl/sync_fifo.sv
rtl/apb_master.sv
rtl/apb_reg_slave.sv
rtl/apb_bridge_top.sv
tb/tb_apb_bridge.sv
